// ==== build.f ====
+incdir+.
icache_pkg.sv
icache_refill_if.sv
icache_tag_store.sv
icache_data_store.sv
icache_plru.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

// ==== icache_config.svh ====
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// geometry
`define ICACHE_ADDR_W 32
`define ICACHE_DATA_W 32
`define ICACHE_WAYS 4
`define ICACHE_WORDS 8
`define ICACHE_SETS 32

// field widths
`define ICACHE_OFS_W 3
`define ICACHE_IDX_W 5
`define ICACHE_TAG_W 22 // addr - index - offset - 2 byte bits
`define ICACHE_WAY_W 2

// address slicing, byte address in
`define ICACHE_OFS_LSB 2
`define ICACHE_IDX_LSB 5
`define ICACHE_TAG_LSB 10

`endif

// ==== icache_ctrl.sv ====
`default_nettype none

`include "icache_config.svh"

module icache_ctrl (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_req_valid,
	input wire logic [`ICACHE_ADDR_W-1:0] i_req_addr,
	input wire logic i_hit,
	input wire logic i_miss,
	input wire logic [`ICACHE_WAY_W-1:0] i_hit_way,
	input wire logic i_init_done,
	input wire logic [`ICACHE_WAYS-1:0][`ICACHE_DATA_W-1:0] i_way_words,
	input wire logic i_mem_rvalid,
	input wire logic [`ICACHE_DATA_W-1:0] i_mem_rdata,
	input wire logic i_mem_rlast,
	input wire logic [`ICACHE_WAY_W-1:0] i_victim_way,
	output logic o_valid,
	output logic [`ICACHE_DATA_W-1:0] o_data,
	output logic o_stall,
	output logic o_rd_en,
	output logic o_mem_req,
	output logic [`ICACHE_ADDR_W-1:0] o_mem_addr,
	output logic o_touch,
	output logic [`ICACHE_IDX_W-1:0] o_touch_index,
	output logic [`ICACHE_WAY_W-1:0] o_touch_way,
	output logic [`ICACHE_IDX_W-1:0] o_victim_index,
	icache_refill_if.ctrl refill
);
	import icache_pkg::*;

	icache_state_e r_state;
	icache_state_e w_state_next;
	logic [`ICACHE_ADDR_W-1:0] r_s2_addr;
	logic [`ICACHE_ADDR_W-1:0] r_miss_addr;
	logic [`ICACHE_WAY_W-1:0] r_victim;
	logic [`ICACHE_OFS_W-1:0] r_beat;
	logic [`ICACHE_WORDS-1:0][`ICACHE_DATA_W-1:0] r_line_buf;
	logic [`ICACHE_IDX_W-1:0] w_miss_index;
	logic w_beat;
	logic w_fwd;

	assign o_stall = !i_init_done || i_miss || (r_state != IDLE);
	assign o_rd_en = i_req_valid && !o_stall;
	assign o_mem_req = (r_state == IDLE) && i_miss;
	assign o_mem_addr = {r_s2_addr[`ICACHE_ADDR_W-1:`ICACHE_IDX_LSB], {`ICACHE_IDX_LSB{1'b0}}};
	assign o_victim_index = r_s2_addr[`ICACHE_IDX_LSB +: `ICACHE_IDX_W];

	assign w_miss_index = r_miss_addr[`ICACHE_IDX_LSB +: `ICACHE_IDX_W];
	assign w_beat = (r_state == RECEIVING) && i_mem_rvalid;
	assign w_fwd = w_beat && (r_beat == r_miss_addr[`ICACHE_OFS_LSB +: `ICACHE_OFS_W]);

	always_comb begin
		w_state_next = r_state;
		case (r_state)
			IDLE:
				if (i_miss)
					w_state_next = RECEIVING;
			RECEIVING:
				if (i_mem_rvalid && i_mem_rlast)
					w_state_next = REFILL;
			REFILL:
				w_state_next = IDLE;
			default:
				w_state_next = IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst)
			r_state <= IDLE;
		else
			r_state <= w_state_next;
	end

	always_ff @(posedge i_clk) begin
		if (o_rd_en)
			r_s2_addr <= i_req_addr; // address now in stage 2
	end

	always_ff @(posedge i_clk) begin
		if (o_mem_req) begin
			r_miss_addr <= r_s2_addr;
			r_victim <= i_victim_way;
		end
	end

	// memory returns word 0 first
	always_ff @(posedge i_clk) begin
		if (i_rst)
			r_beat <= '0;
		else if (o_mem_req)
			r_beat <= '0;
		else if (w_beat)
			r_beat <= r_beat + 1'b1;
	end

	always_ff @(posedge i_clk) begin
		if (w_beat)
			r_line_buf[r_beat] <= i_mem_rdata;
	end

	assign o_valid = i_hit || w_fwd;
	assign o_data = w_fwd ? i_mem_rdata : i_way_words[i_hit_way];

	// lru sees hits and fills
	assign o_touch = i_hit || (r_state == REFILL);
	assign o_touch_index = (r_state == REFILL) ? w_miss_index : o_victim_index;
	assign o_touch_way = (r_state == REFILL) ? r_victim : i_hit_way;

	assign refill.we = (r_state == REFILL);
	assign refill.index = w_miss_index;
	assign refill.way_onehot = `ICACHE_WAYS'(1) << r_victim;
	assign refill.entry = '{valid: 1'b1, tag: r_miss_addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_W]};
	assign refill.line = r_line_buf;

endmodule

`default_nettype wire

// ==== icache_data_store.sv ====
`default_nettype none

`include "icache_config.svh"

module icache_data_store (
	input wire logic i_clk,
	input wire logic i_rd_en,
	input wire logic [`ICACHE_ADDR_W-1:0] i_rd_addr,
	icache_refill_if.data refill,
	output logic [`ICACHE_WAYS-1:0][`ICACHE_DATA_W-1:0] o_way_words
);

	logic [`ICACHE_WORDS-1:0][`ICACHE_DATA_W-1:0] lines [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_WORDS-1:0][`ICACHE_DATA_W-1:0] r_rd_line [`ICACHE_WAYS];
	logic [`ICACHE_OFS_W-1:0] r_rd_ofs;
	logic [`ICACHE_IDX_W-1:0] w_rd_index;

	assign w_rd_index = i_rd_addr[`ICACHE_IDX_LSB +: `ICACHE_IDX_W];

	// whole line in one cycle
	always_ff @(posedge i_clk) begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (refill.we && refill.way_onehot[w])
				lines[w][refill.index] <= refill.line;
		end
	end

	// read alongside the tags
	always_ff @(posedge i_clk) begin
		if (i_rd_en) begin
			for (int w = 0; w < `ICACHE_WAYS; w++)
				r_rd_line[w] <= lines[w][w_rd_index];
			r_rd_ofs <= i_rd_addr[`ICACHE_OFS_LSB +: `ICACHE_OFS_W];
		end
	end

	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++)
			o_way_words[w] = r_rd_line[w][r_rd_ofs]; // stage 2 word
	end

endmodule

`default_nettype wire

// ==== icache_pkg.sv ====
`default_nettype none

`include "icache_config.svh"

package icache_pkg;

	// miss handling states
	typedef enum logic [1:0] {
		IDLE,
		RECEIVING,
		REFILL
	} icache_state_e;

	// maintenance operations
	typedef enum logic [1:0] {
		OP_NONE,
		OP_INV_WAY, // one way, picked by the bits above the index
		OP_INV_SET  // all ways of the set
	} icache_op_e;

	typedef struct packed {
		logic valid;
		logic [`ICACHE_TAG_W-1:0] tag;
	} tag_entry_t;

endpackage

`default_nettype wire

// ==== icache_plru.sv ====
`default_nettype none

`include "icache_config.svh"

module icache_plru (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_touch,
	input wire logic [`ICACHE_IDX_W-1:0] i_touch_index,
	input wire logic [`ICACHE_WAY_W-1:0] i_touch_way,
	input wire logic [`ICACHE_IDX_W-1:0] i_victim_index,
	output logic [`ICACHE_WAY_W-1:0] o_victim_way
);

	// tree bits per set
	logic [`ICACHE_SETS-1:0] r_root;
	logic [`ICACHE_SETS-1:0] r_left;  // ways 0/1
	logic [`ICACHE_SETS-1:0] r_right; // ways 2/3

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_root <= '0;
			r_left <= '0;
			r_right <= '0;
		end else if (i_touch) begin
			// point away from the way just used
			r_root[i_touch_index] <= ~i_touch_way[1];
			if (i_touch_way[1])
				r_right[i_touch_index] <= ~i_touch_way[0];
			else
				r_left[i_touch_index] <= ~i_touch_way[0];
		end
	end

	always_comb begin
		if (r_root[i_victim_index])
			o_victim_way = {1'b1, r_right[i_victim_index]};
		else
			o_victim_way = {1'b0, r_left[i_victim_index]};
	end

endmodule

`default_nettype wire

// ==== icache_refill_if.sv ====
`default_nettype none

`include "icache_config.svh"

interface icache_refill_if;
	import icache_pkg::*;

	logic we; // single cycle write strobe
	logic [`ICACHE_IDX_W-1:0] index;
	logic [`ICACHE_WAYS-1:0] way_onehot;
	tag_entry_t entry;
	logic [`ICACHE_WORDS-1:0][`ICACHE_DATA_W-1:0] line;

	modport ctrl (output we, index, way_onehot, entry, line);

	modport tag (input we, index, way_onehot, entry);

	modport data (input we, index, way_onehot, line);

endinterface

`default_nettype wire

// ==== icache_tag_store.sv ====
`default_nettype none

`include "icache_config.svh"

module icache_tag_store (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_rd_en,
	input wire logic [`ICACHE_ADDR_W-1:0] i_rd_addr,
	input wire icache_pkg::icache_op_e i_op,
	input wire logic [`ICACHE_ADDR_W-1:0] i_op_addr,
	icache_refill_if.tag refill,
	output logic o_hit,
	output logic o_miss,
	output logic [`ICACHE_WAY_W-1:0] o_hit_way,
	output logic o_init_done
);
	import icache_pkg::*;

	tag_entry_t tags [`ICACHE_WAYS][`ICACHE_SETS];
	tag_entry_t r_rd_entry [`ICACHE_WAYS];
	logic [`ICACHE_TAG_W-1:0] r_req_tag;
	logic r_req_valid;
	logic [`ICACHE_IDX_W-1:0] r_sweep_idx;
	logic r_init_done;
	logic [`ICACHE_IDX_W-1:0] w_rd_index;
	logic [`ICACHE_IDX_W-1:0] w_op_index;
	logic [`ICACHE_WAY_W-1:0] w_op_way;
	logic [`ICACHE_WAYS-1:0] w_op_clear;
	logic [`ICACHE_WAYS-1:0] w_way_hit;

	assign w_rd_index = i_rd_addr[`ICACHE_IDX_LSB +: `ICACHE_IDX_W];
	assign w_op_index = i_op_addr[`ICACHE_IDX_LSB +: `ICACHE_IDX_W];
	assign w_op_way = i_op_addr[`ICACHE_TAG_LSB +: `ICACHE_WAY_W];

	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++)
			w_op_clear[w] = (i_op == OP_INV_SET) ||
				(i_op == OP_INV_WAY && w_op_way == `ICACHE_WAY_W'(w));
	end

	// invalidate one set per cycle after reset
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_sweep_idx <= '0;
			r_init_done <= 1'b0;
		end else if (!r_init_done) begin
			r_sweep_idx <= r_sweep_idx + 1'b1;
			if (r_sweep_idx == `ICACHE_IDX_W'(`ICACHE_SETS - 1))
				r_init_done <= 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (!r_init_done)
				tags[w][r_sweep_idx] <= '0;
			else if (w_op_clear[w])
				tags[w][w_op_index] <= '0;
			else if (refill.we && refill.way_onehot[w])
				tags[w][refill.index] <= refill.entry;
		end
	end

	// stage 1 read, all ways
	always_ff @(posedge i_clk) begin
		if (i_rd_en) begin
			for (int w = 0; w < `ICACHE_WAYS; w++)
				r_rd_entry[w] <= tags[w][w_rd_index];
			r_req_tag <= i_rd_addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst)
			r_req_valid <= 1'b0;
		else
			r_req_valid <= i_rd_en;
	end

	// stage 2 compare
	always_comb begin
		o_hit_way = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			w_way_hit[w] = r_rd_entry[w].valid && (r_rd_entry[w].tag == r_req_tag);
			if (w_way_hit[w])
				o_hit_way = `ICACHE_WAY_W'(w);
		end
	end

	assign o_hit = r_req_valid && (|w_way_hit);
	assign o_miss = r_req_valid && !(|w_way_hit);
	assign o_init_done = r_init_done;

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`default_nettype none

`include "icache_config.svh"

module icache_top (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_req_valid,
	input wire logic [`ICACHE_ADDR_W-1:0] i_req_addr,
	output logic o_valid,
	output logic [`ICACHE_DATA_W-1:0] o_data,
	output logic o_stall,
	input wire icache_pkg::icache_op_e i_op,
	input wire logic [`ICACHE_ADDR_W-1:0] i_op_addr,
	output logic o_mem_req,
	output logic [`ICACHE_ADDR_W-1:0] o_mem_addr,
	input wire logic i_mem_rvalid,
	input wire logic [`ICACHE_DATA_W-1:0] i_mem_rdata,
	input wire logic i_mem_rlast
);

	logic w_rd_en;
	logic w_hit;
	logic w_miss;
	logic [`ICACHE_WAY_W-1:0] w_hit_way;
	logic w_init_done;
	logic [`ICACHE_WAYS-1:0][`ICACHE_DATA_W-1:0] w_way_words;
	logic w_touch;
	logic [`ICACHE_IDX_W-1:0] w_touch_index;
	logic [`ICACHE_WAY_W-1:0] w_touch_way;
	logic [`ICACHE_IDX_W-1:0] w_victim_index;
	logic [`ICACHE_WAY_W-1:0] w_victim_way;

	icache_refill_if refill_if0 ();

	icache_tag_store tag_store0 (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_rd_en(w_rd_en),
		.i_rd_addr(i_req_addr),
		.i_op(i_op),
		.i_op_addr(i_op_addr),
		.refill(refill_if0.tag),
		.o_hit(w_hit),
		.o_miss(w_miss),
		.o_hit_way(w_hit_way),
		.o_init_done(w_init_done)
	);

	icache_data_store data_store0 (
		.i_clk(i_clk),
		.i_rd_en(w_rd_en),
		.i_rd_addr(i_req_addr),
		.refill(refill_if0.data),
		.o_way_words(w_way_words)
	);

	icache_plru plru0 (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_touch(w_touch),
		.i_touch_index(w_touch_index),
		.i_touch_way(w_touch_way),
		.i_victim_index(w_victim_index),
		.o_victim_way(w_victim_way)
	);

	icache_ctrl ctrl0 (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_req_valid(i_req_valid),
		.i_req_addr(i_req_addr),
		.i_hit(w_hit),
		.i_miss(w_miss),
		.i_hit_way(w_hit_way),
		.i_init_done(w_init_done),
		.i_way_words(w_way_words),
		.i_mem_rvalid(i_mem_rvalid),
		.i_mem_rdata(i_mem_rdata),
		.i_mem_rlast(i_mem_rlast),
		.i_victim_way(w_victim_way),
		.o_valid(o_valid),
		.o_data(o_data),
		.o_stall(o_stall),
		.o_rd_en(w_rd_en),
		.o_mem_req(o_mem_req),
		.o_mem_addr(o_mem_addr),
		.o_touch(w_touch),
		.o_touch_index(w_touch_index),
		.o_touch_way(w_touch_way),
		.o_victim_index(w_victim_index),
		.refill(refill_if0.ctrl)
	);

endmodule

`default_nettype wire

// ==== tb_icache.sv ====
`default_nettype none

`include "icache_config.svh"

module tb_icache;
	timeunit 1ns;
	timeprecision 1ps;
	import icache_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_REQS = 300;
	localparam int MISS_WORST = 40; // stage 2 plus 8 beats with up to 3 gaps each plus refill

	typedef struct packed {
		icache_op_e op;
		logic [`ICACHE_ADDR_W-1:0] addr;
		logic b2b;
	} item_t;

	logic clk;
	logic rst;
	logic req_valid;
	logic [`ICACHE_ADDR_W-1:0] req_addr;
	icache_op_e op;
	logic [`ICACHE_ADDR_W-1:0] op_addr;
	logic mem_rvalid;
	logic [`ICACHE_DATA_W-1:0] mem_rdata;
	logic mem_rlast;
	logic valid;
	logic [`ICACHE_DATA_W-1:0] data;
	logic stall;
	logic mem_req;
	logic [`ICACHE_ADDR_W-1:0] mem_addr;

	// reference cache state
	logic model_valid [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_TAG_W-1:0] model_tag [`ICACHE_WAYS][`ICACHE_SETS];
	logic plru_r [`ICACHE_SETS];
	logic plru_l [`ICACHE_SETS];
	logic plru_q [`ICACHE_SETS];

	item_t items [$];
	integer seed;
	int cycles;
	int max_cycles;
	int since_reset;
	int last_take;
	logic pending;
	logic pending_b2b;
	logic s2_valid;
	logic s2_hit;
	logic [`ICACHE_ADDR_W-1:0] s2_addr;
	logic resp_active;
	logic [`ICACHE_ADDR_W-1:0] resp_addr;
	int beat;
	logic [1:0] gap_left;
	int refill_phase; // 1 in the refill cycle and 2 in the first idle cycle
	icache_state_e ctrl_state;

	icache_top dut0 (
		.i_clk(clk),
		.i_rst(rst),
		.i_req_valid(req_valid),
		.i_req_addr(req_addr),
		.o_valid(valid),
		.o_data(data),
		.o_stall(stall),
		.i_op(op),
		.i_op_addr(op_addr),
		.o_mem_req(mem_req),
		.o_mem_addr(mem_addr),
		.i_mem_rvalid(mem_rvalid),
		.i_mem_rdata(mem_rdata),
		.i_mem_rlast(mem_rlast)
	);

	always #5 clk = ~clk;

	function automatic logic [`ICACHE_DATA_W-1:0] mem_word(input logic [`ICACHE_ADDR_W-1:0] a);
		logic [31:0] x;
		x = a ^ 32'h5a17c3e9;
		x = x * 32'h9e3779b1;
		x = x ^ (x >> 15);
		return x;
	endfunction

	// a line holds ICACHE_WORDS words of 4 bytes
	function automatic logic [`ICACHE_ADDR_W-1:0] line_of(input logic [`ICACHE_ADDR_W-1:0] a);
		return a & ~(32'(`ICACHE_WORDS * 4) - 32'd1);
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected)
			abort_run($sformatf("FAIL at %0t: %s is %h, expected %h", $time, name,
				actual, expected));
	endtask

	function automatic int model_way_of(input logic [`ICACHE_ADDR_W-1:0] a);
		int set;
		set = a[`ICACHE_IDX_LSB +: `ICACHE_IDX_W];
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (model_valid[w][set] && model_tag[w][set] == a[`ICACHE_TAG_LSB +: `ICACHE_TAG_W])
				return w;
		end
		return -1;
	endfunction

	function automatic int model_victim(input int set);
		if (!plru_r[set])
			return plru_l[set] ? 1 : 0;
		else
			return plru_q[set] ? 3 : 2;
	endfunction

	function automatic void model_touch(input int set, input int way);
		plru_r[set] = (way < 2);
		if (way == 0)
			plru_l[set] = 1'b1;
		else if (way == 1)
			plru_l[set] = 1'b0;
		else if (way == 2)
			plru_q[set] = 1'b1;
		else
			plru_q[set] = 1'b0;
	endfunction

	// returns 1 on a hit and fills the victim on a miss
	function automatic logic model_access(input logic [`ICACHE_ADDR_W-1:0] a);
		int set;
		int way;
		set = a[`ICACHE_IDX_LSB +: `ICACHE_IDX_W];
		way = model_way_of(a);
		if (way >= 0) begin
			model_touch(set, way);
			return 1'b1;
		end
		way = model_victim(set);
		model_valid[way][set] = 1'b1;
		model_tag[way][set] = a[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
		model_touch(set, way);
		return 1'b0;
	endfunction

	function automatic void model_op(input icache_op_e o, input logic [`ICACHE_ADDR_W-1:0] a);
		int set;
		int way;
		set = a[`ICACHE_IDX_LSB +: `ICACHE_IDX_W];
		way = a[`ICACHE_TAG_LSB +: `ICACHE_WAY_W];
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (o == OP_INV_SET || (o == OP_INV_WAY && w == way))
				model_valid[w][set] = 1'b0;
		end
	endfunction

	// way field of the op address points at the way holding the line
	function automatic logic [`ICACHE_ADDR_W-1:0] op_target(input item_t it);
		logic [`ICACHE_ADDR_W-1:0] t;
		int way;
		t = it.addr;
		way = model_way_of(it.addr);
		if (way < 0)
			way = 0;
		if (it.op == OP_INV_WAY)
			t[`ICACHE_TAG_LSB +: `ICACHE_WAY_W] = way[1:0];
		return t;
	endfunction

	function automatic logic [`ICACHE_ADDR_W-1:0] make_addr(input int tag, input int set,
			input int ofs);
		return (32'(tag) << `ICACHE_TAG_LSB) | (32'(set) << `ICACHE_IDX_LSB) |
			(32'(ofs) << `ICACHE_OFS_LSB);
	endfunction

	task automatic add_item(input icache_op_e o, input int tag, input int set, input int ofs,
			input logic b2b);
		item_t it;
		it.op = o;
		it.addr = make_addr(tag, set, ofs);
		it.b2b = b2b;
		items.push_back(it);
	endtask

	task automatic build_items();
		logic [31:0] rnd;
		for (int i = 0; i < RANDOM_REQS; i++) begin
			rnd = $random(seed);
			add_item(OP_NONE, rnd[7:4] % 6, rnd[8], rnd[2:0], 1'b0);
		end
		// five lines in set 7 followed by the four survivors and the evicted one
		for (int t = 0; t < 5; t++)
			add_item(OP_NONE, 100 + t, 7, t, 1'b0);
		for (int t = 1; t < 5; t++)
			add_item(OP_NONE, 100 + t, 7, 7 - t, 1'b0);
		add_item(OP_NONE, 100, 7, 3, 1'b0);
		// maintenance on set 9
		for (int t = 0; t < 4; t++)
			add_item(OP_NONE, 200 + t, 9, 1, 1'b0);
		add_item(OP_INV_WAY, 200, 9, 0, 1'b0);
		for (int t = 1; t < 4; t++)
			add_item(OP_NONE, 200 + t, 9, 2, 1'b0);
		add_item(OP_NONE, 200, 9, 5, 1'b0);
		add_item(OP_INV_SET, 201, 9, 0, 1'b0);
		add_item(OP_NONE, 201, 9, 6, 1'b0);
		add_item(OP_NONE, 103, 7, 0, 1'b0);
		// one line followed by every word of it back to back
		add_item(OP_NONE, 300, 12, 0, 1'b0);
		for (int o = 0; o < `ICACHE_WORDS; o++)
			add_item(OP_NONE, 300, 12, o, o != 0);
	endtask

	// per clock edge check the pre-edge outputs, update the model and drive the next inputs
	task automatic step();
		logic exp_valid;
		logic [`ICACHE_DATA_W-1:0] exp_data;
		logic exp_mem_req;
		logic [31:0] rnd;
		item_t head;
		cycles++;
		since_reset++;
		if (cycles > max_cycles) begin
			ctrl_state = dut0.ctrl0.r_state;
			abort_run($sformatf("timeout after %0d cycles, controller in state %s", cycles,
				ctrl_state.name()));
		end
		if (since_reset <= `ICACHE_SETS)
			compare("o_stall during sweep", stall, 1'b1);
		else if (since_reset == `ICACHE_SETS + 1)
			compare("o_stall after sweep", stall, 1'b0);
		if (op != OP_NONE)
			model_op(op, op_addr); // takes effect at this edge

		exp_valid = 1'b0;
		exp_data = '0;
		exp_mem_req = 1'b0;
		if (s2_valid && s2_hit) begin
			exp_valid = 1'b1;
			exp_data = mem_word(s2_addr);
		end else if (s2_valid) begin
			exp_mem_req = 1'b1;
		end
		if (resp_active && mem_rvalid && beat == resp_addr[`ICACHE_OFS_LSB +: `ICACHE_OFS_W]) begin
			exp_valid = 1'b1; // forwarded word
			exp_data = mem_word(resp_addr);
		end
		compare("o_valid", valid, exp_valid);
		if (exp_valid)
			compare("o_data", data, exp_data);
		compare("o_mem_req", mem_req, exp_mem_req);
		if (exp_mem_req) begin
			compare("o_mem_addr", mem_addr, line_of(s2_addr));
			compare("o_stall on miss", stall, 1'b1);
		end

		if (refill_phase == 1) begin
			compare("o_stall in refill", stall, 1'b1);
			refill_phase = 2;
		end else if (refill_phase == 2) begin
			compare("o_stall after refill", stall, 1'b0);
			refill_phase = 0;
		end
		if (resp_active) begin
			compare("o_stall while receiving", stall, 1'b1);
			if (mem_rvalid) begin
				beat++;
				if (beat == `ICACHE_WORDS) begin
					resp_active = 1'b0;
					refill_phase = 1;
				end
			end
		end
		if (s2_valid && !s2_hit) begin
			resp_active = 1'b1;
			resp_addr = s2_addr;
			beat = 0;
			rnd = $random(seed);
			gap_left = rnd[1:0];
		end
		s2_valid = 1'b0;

		if (pending && !stall) begin
			if (pending_b2b && last_take != cycles - 1)
				abort_run("back-to-back read was not taken on the cycle after the previous one");
			s2_hit = model_access(req_addr);
			s2_valid = 1'b1;
			s2_addr = req_addr;
			last_take = cycles;
			pending = 1'b0;
		end

		// memory responder
		if (resp_active && gap_left != 0) begin
			mem_rvalid <= 1'b0;
			mem_rlast <= 1'b0;
			gap_left = gap_left - 2'd1;
		end else if (resp_active) begin
			mem_rvalid <= 1'b1;
			mem_rdata <= mem_word(line_of(resp_addr) + 32'(beat * 4));
			mem_rlast <= (beat == `ICACHE_WORDS - 1);
			rnd = $random(seed);
			gap_left = rnd[1:0];
		end else begin
			mem_rvalid <= 1'b0;
			mem_rlast <= 1'b0;
		end

		op <= OP_NONE;
		if (!pending && items.size() != 0) begin
			head = items[0];
			if (head.op == OP_NONE) begin
				req_valid <= 1'b1;
				req_addr <= head.addr;
				pending = 1'b1;
				pending_b2b = head.b2b;
				void'(items.pop_front());
			end else begin
				req_valid <= 1'b0;
				// only into a quiet cache with nothing presented last cycle
				if (!req_valid && !resp_active && refill_phase == 0 && op == OP_NONE &&
						since_reset > `ICACHE_SETS) begin
					op <= head.op;
					op_addr <= op_target(head);
					void'(items.pop_front());
				end
			end
		end else if (!pending) begin
			req_valid <= 1'b0;
		end
	endtask

	initial begin
		seed = 32'h3174;
		clk = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		op = OP_NONE;
		op_addr = '0;
		mem_rvalid = 1'b0;
		mem_rdata = '0;
		mem_rlast = 1'b0;
		cycles = 0;
		since_reset = 0;
		last_take = -10;
		pending = 1'b0;
		pending_b2b = 1'b0;
		s2_valid = 1'b0;
		s2_hit = 1'b0;
		s2_addr = '0;
		resp_active = 1'b0;
		resp_addr = '0;
		beat = 0;
		gap_left = '0;
		refill_phase = 0;
		for (int s = 0; s < `ICACHE_SETS; s++) begin
			plru_r[s] = 1'b0;
			plru_l[s] = 1'b0;
			plru_q[s] = 1'b0;
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				model_valid[w][s] = 1'b0;
				model_tag[w][s] = '0;
			end
		end
		build_items();
		max_cycles = items.size() * MISS_WORST + `ICACHE_SETS + 20;

		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		while (items.size() != 0 || pending || s2_valid || resp_active || refill_phase != 0 ||
				op != OP_NONE) begin
			@(posedge clk);
			step();
		end
		repeat (4) begin
			@(posedge clk);
			step(); // no stray outputs afterwards
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
